// File: bft_pkg.sv
`default_nettype none

package bft_pkg;

	// network size
	localparam int NUM_LEAVES = 8;
	localparam int NUM_LEVELS = 3;

	// packet fields
	localparam int ADDR_W    = $clog2(NUM_LEAVES);
	localparam int PAYLOAD_W = 8;
	localparam int PKT_W     = 1 + ADDR_W + PAYLOAD_W;

	// bit positions inside a packet word
	localparam int VALID_BIT = PKT_W - 1;
	localparam int DEST_LSB  = PAYLOAD_W;

	typedef logic [ADDR_W-1:0]    leaf_addr_t;
	typedef logic [PAYLOAD_W-1:0] payload_t;
	// valid, destination, payload from msb down
	typedef logic [PKT_W-1:0]     pkt_t;

	// wanted direction of an input, or source select of an output mux
	typedef enum logic [1:0] {
		DIR_VOID  = 2'b00,
		DIR_LEFT  = 2'b01,
		DIR_RIGHT = 2'b10,
		DIR_UP    = 2'b11
	} dir_t;

endpackage

`default_nettype wire

// File: t_arbiter.sv
`default_nettype none

module t_arbiter #(
	parameter int LEVEL = 1
) (
	input  bft_pkg::dir_t d_l_i,
	input  bft_pkg::dir_t d_r_i,
	input  bft_pkg::dir_t d_u_i,
	output bft_pkg::dir_t sel_l_o,
	output bft_pkg::dir_t sel_r_o,
	output bft_pkg::dir_t sel_u_o
);

	import bft_pkg::*;

	generate
		if (LEVEL == 0) begin : g_root
			// root has no up link, only left and right compete
			always_comb begin
				sel_l_o = DIR_VOID;
				sel_r_o = DIR_VOID;
				sel_u_o = DIR_VOID;
				if (d_l_i == DIR_LEFT)
					sel_l_o = DIR_LEFT;
				if (d_r_i == DIR_RIGHT)
					sel_r_o = DIR_RIGHT;
				// crossing traffic, loser bounces back where it came from
				if (d_l_i == DIR_RIGHT) begin
					if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_LEFT;
					else
						sel_l_o = DIR_LEFT;
				end
				if (d_r_i == DIR_LEFT) begin
					if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_RIGHT;
					else
						sel_r_o = DIR_RIGHT;
				end
			end
		end else begin : g_inner
			always_comb begin
				sel_l_o = DIR_VOID;
				sel_r_o = DIR_VOID;
				sel_u_o = DIR_VOID;

				// turnback packets keep their arrival side
				if (d_l_i == DIR_LEFT)
					sel_l_o = DIR_LEFT;
				if (d_r_i == DIR_RIGHT)
					sel_r_o = DIR_RIGHT;

				// up input, turnback or down-going
				if (d_u_i == DIR_UP) begin
					sel_u_o = DIR_UP;
				end else if (d_u_i == DIR_LEFT) begin
					if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_UP;
					else
						sel_u_o = DIR_UP;
				end else if (d_u_i == DIR_RIGHT) begin
					if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_UP;
					else
						sel_u_o = DIR_UP;
				end

				// left input going across or up
				if (d_l_i == DIR_RIGHT) begin
					if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_LEFT;
					else if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_LEFT;
					else
						sel_u_o = DIR_LEFT;
				end else if (d_l_i == DIR_UP) begin
					if (sel_u_o == DIR_VOID)
						sel_u_o = DIR_LEFT;
					else if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_LEFT;
					else
						sel_r_o = DIR_LEFT;
				end

				// right input takes whatever is left over
				if (d_r_i == DIR_LEFT) begin
					if (sel_l_o == DIR_VOID)
						sel_l_o = DIR_RIGHT;
					else if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_RIGHT;
					else
						sel_u_o = DIR_RIGHT;
				end else if (d_r_i == DIR_UP) begin
					if (sel_u_o == DIR_VOID)
						sel_u_o = DIR_RIGHT;
					else if (sel_r_o == DIR_VOID)
						sel_r_o = DIR_RIGHT;
					else
						sel_l_o = DIR_RIGHT;
				end
			end
		end
	endgenerate

endmodule

`default_nettype wire

// File: t_switch.sv
`default_nettype none

module t_switch #(
	parameter int                  LEVEL     = 1,
	parameter bft_pkg::leaf_addr_t NODE_ADDR = '0
) (
	input  wire           clk,
	input  wire           reset,
	input  bft_pkg::pkt_t l_pkt_i,
	input  bft_pkg::pkt_t r_pkt_i,
	input  bft_pkg::pkt_t u_pkt_i,
	output bft_pkg::pkt_t l_pkt_o,
	output bft_pkg::pkt_t r_pkt_o,
	output bft_pkg::pkt_t u_pkt_o
);

	import bft_pkg::*;

	dir_t d_l;
	dir_t d_r;
	dir_t d_u;
	dir_t sel_l;
	dir_t sel_r;
	dir_t sel_u;

	// top LEVEL address bits must match the node prefix, at the root
	// the shift clears everything so only the top bit matters
	function automatic dir_t decode_dir(input pkt_t pkt);
		leaf_addr_t dest;
		dest = pkt[DEST_LSB +: ADDR_W];
		if (!pkt[VALID_BIT])
			return DIR_VOID;
		if ((dest >> (ADDR_W - LEVEL)) != NODE_ADDR)
			return DIR_UP;
		if (dest[ADDR_W-1-LEVEL])
			return DIR_RIGHT;
		return DIR_LEFT;
	endfunction

	function automatic pkt_t pick(input dir_t sel, input pkt_t l_pkt, input pkt_t r_pkt,
			input pkt_t u_pkt);
		case (sel)
			DIR_LEFT:  return l_pkt;
			DIR_RIGHT: return r_pkt;
			DIR_UP:    return u_pkt;
			default:   return '0;
		endcase
	endfunction

	assign d_l = decode_dir(l_pkt_i);
	assign d_r = decode_dir(r_pkt_i);
	assign d_u = decode_dir(u_pkt_i);

	t_arbiter #(
		.LEVEL(LEVEL)
	) i_t_arbiter (
		.d_l_i  (d_l),
		.d_r_i  (d_r),
		.d_u_i  (d_u),
		.sel_l_o(sel_l),
		.sel_r_o(sel_r),
		.sel_u_o(sel_u)
	);

	// one register stage per switch
	always_ff @(posedge clk) begin
		if (reset) begin
			l_pkt_o <= '0;
			r_pkt_o <= '0;
			u_pkt_o <= '0;
		end else begin
			l_pkt_o <= pick(sel_l, l_pkt_i, r_pkt_i, u_pkt_i);
			r_pkt_o <= pick(sel_r, l_pkt_i, r_pkt_i, u_pkt_i);
			u_pkt_o <= pick(sel_u, l_pkt_i, r_pkt_i, u_pkt_i);
		end
	end

endmodule

`default_nettype wire

// File: leaf_port.sv
`default_nettype none

module leaf_port #(
	parameter bft_pkg::leaf_addr_t LEAF_ADDR = '0
) (
	input  wire           clk,
	input  wire           reset,
	input  bft_pkg::pkt_t bus_i,
	input  bft_pkg::pkt_t pe_pkt_i,
	output bft_pkg::pkt_t bus_o,
	output bft_pkg::pkt_t leaf_pkt_o,
	output logic          resend_o
);

	import bft_pkg::*;

	logic bus_valid;
	logic for_me;

	assign bus_valid = bus_i[VALID_BIT];
	assign for_me    = bus_i[DEST_LSB +: ADDR_W] == LEAF_ADDR;

	// slot busy with a packet for some other leaf
	assign resend_o = bus_valid && !for_me;

	always_ff @(posedge clk) begin
		if (reset) begin
			leaf_pkt_o <= '0;
			bus_o      <= '0;
		end else begin
			if (bus_valid && for_me)
				leaf_pkt_o <= bus_i;
			else
				leaf_pkt_o <= '0;
			// transit packet keeps circulating, local word is dropped
			if (resend_o)
				bus_o <= bus_i;
			else
				bus_o <= pe_pkt_i;
		end
	end

endmodule

`default_nettype wire

// File: bft_top.sv
`default_nettype none

module bft_top (
	input  wire                                clk,
	input  wire                                reset,
	input  bft_pkg::pkt_t                      pe_pkt_i [bft_pkg::NUM_LEAVES],
	output bft_pkg::pkt_t                      leaf_pkt_o [bft_pkg::NUM_LEAVES],
	output logic [bft_pkg::NUM_LEAVES-1:0]     resend_o
);

	import bft_pkg::*;

	// links indexed like a heap, node k has children 2k and 2k+1,
	// switches are 1..NUM_LEAVES-1 and leaf n sits at NUM_LEAVES+n
	// up_w[k] is the word node k sends to its parent
	// dn_w[k] is the word the parent sends down to node k
	pkt_t up_w [2:2*NUM_LEAVES-1];
	pkt_t dn_w [2:2*NUM_LEAVES-1];

	generate
		for (genvar lvl = 0; lvl < NUM_LEVELS; lvl++) begin : g_level
			for (genvar n = 0; n < (1 << lvl); n++) begin : g_node
				localparam int K = (1 << lvl) + n;

				if (lvl == 0) begin : g_root
					// nothing above the root
					t_switch #(
						.LEVEL    (lvl),
						.NODE_ADDR(leaf_addr_t'(n))
					) i_t_switch (
						.clk    (clk),
						.reset  (reset),
						.l_pkt_i(up_w[2*K]),
						.r_pkt_i(up_w[2*K+1]),
						.u_pkt_i(pkt_t'(0)),
						.l_pkt_o(dn_w[2*K]),
						.r_pkt_o(dn_w[2*K+1]),
						.u_pkt_o()
					);
				end else begin : g_inner
					t_switch #(
						.LEVEL    (lvl),
						.NODE_ADDR(leaf_addr_t'(n))
					) i_t_switch (
						.clk    (clk),
						.reset  (reset),
						.l_pkt_i(up_w[2*K]),
						.r_pkt_i(up_w[2*K+1]),
						.u_pkt_i(dn_w[K]),
						.l_pkt_o(dn_w[2*K]),
						.r_pkt_o(dn_w[2*K+1]),
						.u_pkt_o(up_w[K])
					);
				end
			end
		end

		for (genvar i = 0; i < NUM_LEAVES; i++) begin : g_leaf
			leaf_port #(
				.LEAF_ADDR(leaf_addr_t'(i))
			) i_leaf_port (
				.clk       (clk),
				.reset     (reset),
				.bus_i     (dn_w[NUM_LEAVES+i]),
				.pe_pkt_i  (pe_pkt_i[i]),
				.bus_o     (up_w[NUM_LEAVES+i]),
				.leaf_pkt_o(leaf_pkt_o[i]),
				.resend_o  (resend_o[i])
			);
		end
	endgenerate

endmodule

`default_nettype wire

// File: bft_asserts.sv
`default_nettype none

module bft_asserts (
	input  wire                           clk_i,
	input  wire                           reset_i,
	input  bft_pkg::pkt_t                 leaf_pkt_i [bft_pkg::NUM_LEAVES],
	input  bft_pkg::pkt_t                 dn_i [2:2*bft_pkg::NUM_LEAVES-1],
	input  bft_pkg::pkt_t                 up_i [2:2*bft_pkg::NUM_LEAVES-1],
	input  wire [bft_pkg::NUM_LEAVES-1:0] resend_i
);

	import bft_pkg::*;

	for (genvar i = 0; i < NUM_LEAVES; i++) begin : g_leaf
		a_own_addr: assert property (@(posedge clk_i) disable iff (reset_i)
			leaf_pkt_i[i][VALID_BIT] |-> leaf_pkt_i[i][DEST_LSB +: ADDR_W] == leaf_addr_t'(i))
			else $error("leaf %0d delivered a packet for another leaf", i);

		// synchronous reset clears outputs one edge later
		a_reset_clear: assert property (@(posedge clk_i)
			reset_i |=> leaf_pkt_i[i] == '0 && !resend_i[i])
			else $error("leaf %0d outputs not cleared by reset", i);

		// busy slot means a valid transit word, sent back up unchanged
		a_resend_valid: assert property (@(posedge clk_i) disable iff (reset_i)
			resend_i[i] |=> up_i[NUM_LEAVES+i][VALID_BIT]
				&& up_i[NUM_LEAVES+i] == $past(dn_i[NUM_LEAVES+i]))
			else $error("leaf %0d raised resend without a valid transit word", i);
	end

endmodule

bind bft_top bft_asserts i_bft_asserts (
	.clk_i     (clk),
	.reset_i   (reset),
	.leaf_pkt_i(leaf_pkt_o),
	.dn_i      (dn_w),
	.up_i      (up_w),
	.resend_i  (resend_o)
);

`default_nettype wire

// File: tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 10
) (
	output logic clk_o,
	output logic reset_o
);

	initial begin
		clk_o = 1'b0;
		forever #(PERIOD / 2) clk_o = ~clk_o;
	end

	// release just after an edge, like the rest of the stimulus
	initial begin
		reset_o = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_o);
		#1;
		reset_o = 1'b0;
	end

endmodule

`default_nettype wire

// File: tb_checker.sv
`default_nettype none

module tb_checker (
	input  wire                           clk_i,
	input  wire                           reset_i,
	input  bft_pkg::pkt_t                 pe_pkt_i [bft_pkg::NUM_LEAVES],
	input  bft_pkg::pkt_t                 leaf_pkt_i [bft_pkg::NUM_LEAVES],
	input  wire [bft_pkg::NUM_LEAVES-1:0] resend_i,
	output int                            pending_o,
	output int                            errors_o,
	output int                            refused_o
);

	import bft_pkg::*;

	// accepted but not yet delivered, per destination and tag
	int outstanding [NUM_LEAVES][2**PAYLOAD_W];
	int pending = 0;
	int errors  = 0;
	int refused = 0;

	assign pending_o = pending;
	assign errors_o  = errors;
	assign refused_o = refused;

	task automatic report_mismatch(input string msg);
		$display("Fail %0t: %s", $time, msg);
		errors++;
	endtask

	// mid-cycle, inputs and registered outputs are settled here
	always @(negedge clk_i) begin
		leaf_addr_t dest;
		payload_t   tag;
		if (!reset_i) begin
			for (int n = 0; n < NUM_LEAVES; n++) begin
				dest = pe_pkt_i[n][DEST_LSB +: ADDR_W];
				tag  = pe_pkt_i[n][PAYLOAD_W-1:0];
				if (pe_pkt_i[n][VALID_BIT] && resend_i[n]) begin
					refused++;
				end else if (pe_pkt_i[n][VALID_BIT]) begin
					outstanding[dest][tag]++;
					pending++;
				end
			end
			for (int n = 0; n < NUM_LEAVES; n++) begin
				dest = leaf_pkt_i[n][DEST_LSB +: ADDR_W];
				tag  = leaf_pkt_i[n][PAYLOAD_W-1:0];
				if (!leaf_pkt_i[n][VALID_BIT]) begin
					if (leaf_pkt_i[n] != '0)
						report_mismatch($sformatf("leaf %0d idle word %h, expected 0", n,
							leaf_pkt_i[n]));
				end else if (dest != leaf_addr_t'(n)) begin
					report_mismatch($sformatf("leaf %0d got a packet for leaf %0d", n, dest));
				end else if (outstanding[dest][tag] == 0) begin
					report_mismatch($sformatf("leaf %0d got tag %h, not outstanding", n, tag));
				end else begin
					outstanding[dest][tag]--;
					pending--;
				end
			end
			// a busy slot means some accepted packet still circulates
			if (resend_i != '0 && pending == 0)
				report_mismatch($sformatf("resend_o %b with nothing in flight", resend_i));
		end
	end

endmodule

`default_nettype wire

// File: tb_top.sv
`default_nettype none

module tb_top;

	import bft_pkg::*;

	localparam int DRAIN_CYCLES = 200;
	localparam int IDLE_CYCLES  = 20;
	localparam int SWEEP_CYCLES = NUM_LEAVES * NUM_LEAVES * 20;
	localparam int RAND_CYCLES  = 200;
	localparam int FULL_CYCLES  = 100;
	localparam int HOT_CYCLES   = 120;
	// reset, every injection phase and one drain window per test
	localparam int CYCLE_LIMIT  = 10 + IDLE_CYCLES + SWEEP_CYCLES + RAND_CYCLES
		+ FULL_CYCLES + HOT_CYCLES + 5 * DRAIN_CYCLES;

	logic                  clk;
	logic                  reset;
	pkt_t                  pe_pkt [NUM_LEAVES];
	pkt_t                  leaf_pkt [NUM_LEAVES];
	logic [NUM_LEAVES-1:0] resend;
	int                    pending;
	int                    errors;
	int                    refused;
	int                    seed;
	int                    cycle_cnt = 0;
	int                    passed    = 0;
	int                    failed    = 0;
	// next tag per destination keeps payloads unique
	payload_t              tag_next [NUM_LEAVES];

	tb_clock i_tb_clock (
		.clk_o  (clk),
		.reset_o(reset)
	);

	bft_top i_bft_top (
		.clk       (clk),
		.reset     (reset),
		.pe_pkt_i  (pe_pkt),
		.leaf_pkt_o(leaf_pkt),
		.resend_o  (resend)
	);

	tb_checker i_tb_checker (
		.clk_i     (clk),
		.reset_i   (reset),
		.pe_pkt_i  (pe_pkt),
		.leaf_pkt_i(leaf_pkt),
		.resend_i  (resend),
		.pending_o (pending),
		.errors_o  (errors),
		.refused_o (refused)
	);

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > CYCLE_LIMIT) begin
			$display("timeout, run still going after %0d cycles", CYCLE_LIMIT);
			$display("sim failed");
			$finish;
		end
	end

	task automatic step;
		@(posedge clk);
		#1;
	endtask

	// one chance in four per call unless every is set
	task automatic generate_word(input bit every, input bit hot, output pkt_t w);
		logic [31:0] rnd;
		leaf_addr_t  dest;
		rnd  = $random(seed);
		dest = hot ? leaf_addr_t'(0) : rnd[ADDR_W+1:2];
		w    = '0;
		if (every || rnd[1:0] == 2'd0) begin
			w = {1'b1, dest, tag_next[dest]};
			tag_next[dest]++;
		end
	endtask

	// refused words are offered again until a free slot takes them
	task automatic run_traffic(input int cycles, input bit every, input bit hot);
		pkt_t                  offer [NUM_LEAVES];
		logic [NUM_LEAVES-1:0] taken;
		offer = '{default: '0};
		repeat (cycles) begin
			@(negedge clk);
			foreach (offer[n])
				taken[n] = offer[n][VALID_BIT] && !resend[n];
			step();
			foreach (offer[n])
				if (taken[n] || !offer[n][VALID_BIT])
					generate_word(every, hot, offer[n]);
			pe_pkt = offer;
		end
		pe_pkt = '{default: '0};
	endtask

	task automatic wait_drain(input int limit);
		int waited;
		waited = 0;
		while (pending != 0 && waited < limit) begin
			step();
			waited++;
		end
	endtask

	task automatic finish_test(input string name, input int err_before, input bit ok);
		wait_drain(DRAIN_CYCLES);
		if (pending != 0)
			$display("%s: %0d packets were never delivered", name, pending);
		if (ok && pending == 0 && errors == err_before) begin
			passed++;
			$display("%s: ok", name);
		end else begin
			failed++;
			$display("%s: FAILED", name);
		end
		tag_next = '{default: '0};
	endtask

	initial begin
		int err0;
		int ref0;
		bit accepted;
		seed     = 32'h6795;
		pe_pkt   = '{default: '0};
		tag_next = '{default: '0};
		@(negedge reset);

		err0 = errors;
		repeat (IDLE_CYCLES) step();
		finish_test("idle after reset", err0, 1'b1);

		err0 = errors;
		for (int s = 0; s < NUM_LEAVES; s++) begin
			for (int d = 0; d < NUM_LEAVES; d++) begin
				pe_pkt[s] = {1'b1, leaf_addr_t'(d), tag_next[d]};
				tag_next[d]++;
				accepted = 1'b0;
				while (!accepted) begin
					@(negedge clk);
					accepted = !resend[s];
					step();
				end
				pe_pkt[s] = '0;
				wait_drain(16);
			end
		end
		finish_test("directed sweep", err0, 1'b1);

		err0 = errors;
		run_traffic(RAND_CYCLES, 1'b0, 1'b0);
		finish_test("random traffic", err0, 1'b1);

		err0 = errors;
		ref0 = refused;
		run_traffic(FULL_CYCLES, 1'b1, 1'b0);
		if (refused == ref0)
			$display("full load: resend_o was never raised");
		finish_test("full load", err0, refused != ref0);

		err0 = errors;
		ref0 = refused;
		run_traffic(HOT_CYCLES, 1'b1, 1'b1);
		if (refused == ref0)
			$display("hotspot: no leaf ever saw a busy slot");
		finish_test("hotspot", err0, refused != ref0);

		$display("%0d tests passed, %0d failed, %0d check errors", passed, failed, errors);
		if (failed == 0 && errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
bft_pkg.sv
t_arbiter.sv
t_switch.sv
leaf_port.sv
bft_top.sv
bft_asserts.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// File: run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
